/* subsystem_cfg.svh */
/*
  Subsystem configuration.
  Bus widths, code SRAM depth, address window and lane select bits,
  and the AXI response code used by the memory path.
*/
`ifndef SUBSYSTEM_CFG_SVH
`define SUBSYSTEM_CFG_SVH

// byte address and bus data widths.
`define SUB_ADDR_BITS 32
`define SUB_DATA_BITS 64

// peripheral message port data width.
`define SUB_PERIPH_DATA_BITS 32

// code SRAM word index, 256 words.
`define SUB_SRAM_INDEX_BITS 8

// address bit that selects the SRAM window.
`define SUB_SRAM_SELECT_BIT 31

// address bit that selects the peripheral half.
`define SUB_LANE_BIT 2

`define SUB_RESP_OKAY 2'b00

`endif

/* subsystem_pkg.sv */
/*
  Subsystem package.
  Vector types for addresses, data, strobes and responses,
  and the routing and state machine enums.
*/
`include "subsystem_cfg.svh"

package subsystem_pkg;

  typedef logic [`SUB_ADDR_BITS-1:0] addr_t;
  typedef logic [`SUB_DATA_BITS-1:0] data_t;
  typedef logic [`SUB_DATA_BITS/8-1:0] strb_t;
  typedef logic [1:0] resp_t;

  typedef logic [`SUB_PERIPH_DATA_BITS-1:0] periph_data_t;
  typedef logic [`SUB_PERIPH_DATA_BITS/8-1:0] periph_strb_t;

  typedef logic [`SUB_SRAM_INDEX_BITS-1:0] sram_index_t;

  // decoder routing target.
  typedef enum logic {sram, periph} target_e;

  typedef enum logic [1:0] {wr_idle, wr_data, wr_resp} wr_state_e;

  typedef enum logic [1:0] {rd_idle, rd_busy, rd_resp} rd_state_e;

endpackage

/* axi_lite_if.sv */
/*
  AXI4-Lite bus.
  Five channels with valid/ready handshakes, no bursts or IDs.
*/
`timescale 1ns/1ps

interface axi_lite_if;

  subsystem_pkg::addr_t awaddr;
  logic awvalid;
  logic awready;

  subsystem_pkg::data_t wdata;
  subsystem_pkg::strb_t wstrb;
  logic wvalid;
  logic wready;

  subsystem_pkg::resp_t bresp;
  logic bvalid;
  logic bready;

  subsystem_pkg::addr_t araddr;
  logic arvalid;
  logic arready;

  subsystem_pkg::data_t rdata;
  subsystem_pkg::resp_t rresp;
  logic rvalid;
  logic rready;

  modport manager (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output araddr, arvalid, rready,
    input awready, wready, bresp, bvalid,
    input arready, rdata, rresp, rvalid
  );

  modport subordinate (
    input awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input araddr, arvalid, rready,
    output awready, wready, bresp, bvalid,
    output arready, rdata, rresp, rvalid
  );

endinterface

/* sram_if.sv */
/*
  Code SRAM port.
  One read port with a registered result and one byte-enabled write port.
*/
`timescale 1ns/1ps

interface sram_if;

  subsystem_pkg::sram_index_t read_index;
  logic read_enable;
  subsystem_pkg::data_t read_data;

  subsystem_pkg::sram_index_t write_index;
  subsystem_pkg::data_t write_data;
  subsystem_pkg::strb_t write_strb;
  logic write_enable;

  modport controller (
    output read_index, read_enable, write_index, write_data, write_strb, write_enable,
    input read_data
  );

  modport memory (
    input read_index, read_enable, write_index, write_data, write_strb, write_enable,
    output read_data
  );

endinterface

/* axi_addr_decoder.sv */
/*
  AXI4-Lite address decoder.
  Routes each write and read to the code SRAM or the peripheral port
  by the window bit of its address and returns the target's response.
*/
`timescale 1ns/1ps
`include "subsystem_cfg.svh"

module axi_addr_decoder (
  input logic clock,
  input logic reset,
  axi_lite_if.subordinate up,
  axi_lite_if.manager sram_bus,
  axi_lite_if.manager periph_bus
);

  subsystem_pkg::wr_state_e wr_state;
  subsystem_pkg::rd_state_e rd_state;
  subsystem_pkg::target_e wr_target;
  subsystem_pkg::target_e rd_target;
  subsystem_pkg::target_e aw_pick;
  subsystem_pkg::target_e ar_pick;
  logic aw_open;
  logic ar_open;
  logic w_phase;
  logic b_phase;
  logic r_phase;
  logic wr_to_sram;
  logic rd_to_sram;

  assign aw_pick = up.awaddr[`SUB_SRAM_SELECT_BIT] ? subsystem_pkg::sram : subsystem_pkg::periph;
  assign ar_pick = up.araddr[`SUB_SRAM_SELECT_BIT] ? subsystem_pkg::sram : subsystem_pkg::periph;

  // new address only offered while that direction is idle.
  assign aw_open = (wr_state == subsystem_pkg::wr_idle) && up.awvalid;
  assign ar_open = (rd_state == subsystem_pkg::rd_idle) && up.arvalid;

  assign w_phase = wr_state == subsystem_pkg::wr_data;
  assign b_phase = wr_state == subsystem_pkg::wr_resp;
  assign r_phase = rd_state == subsystem_pkg::rd_busy;
  assign wr_to_sram = wr_target == subsystem_pkg::sram;
  assign rd_to_sram = rd_target == subsystem_pkg::sram;

  // write address.
  assign sram_bus.awaddr = up.awaddr;
  assign periph_bus.awaddr = up.awaddr;
  assign sram_bus.awvalid = aw_open && (aw_pick == subsystem_pkg::sram);
  assign periph_bus.awvalid = aw_open && (aw_pick == subsystem_pkg::periph);
  assign up.awready = aw_open &&
                      ((aw_pick == subsystem_pkg::sram) ? sram_bus.awready : periph_bus.awready);

  // write data, only to the registered target.
  assign sram_bus.wdata = up.wdata;
  assign periph_bus.wdata = up.wdata;
  assign sram_bus.wstrb = up.wstrb;
  assign periph_bus.wstrb = up.wstrb;
  assign sram_bus.wvalid = w_phase && up.wvalid && wr_to_sram;
  assign periph_bus.wvalid = w_phase && up.wvalid && !wr_to_sram;
  assign up.wready = w_phase && (wr_to_sram ? sram_bus.wready : periph_bus.wready);

  // write response.
  assign sram_bus.bready = b_phase && up.bready && wr_to_sram;
  assign periph_bus.bready = b_phase && up.bready && !wr_to_sram;
  assign up.bvalid = b_phase && (wr_to_sram ? sram_bus.bvalid : periph_bus.bvalid);
  assign up.bresp = wr_to_sram ? sram_bus.bresp : periph_bus.bresp;

  // read address.
  assign sram_bus.araddr = up.araddr;
  assign periph_bus.araddr = up.araddr;
  assign sram_bus.arvalid = ar_open && (ar_pick == subsystem_pkg::sram);
  assign periph_bus.arvalid = ar_open && (ar_pick == subsystem_pkg::periph);
  assign up.arready = ar_open &&
                      ((ar_pick == subsystem_pkg::sram) ? sram_bus.arready : periph_bus.arready);

  // read data.
  assign sram_bus.rready = r_phase && up.rready && rd_to_sram;
  assign periph_bus.rready = r_phase && up.rready && !rd_to_sram;
  assign up.rvalid = r_phase && (rd_to_sram ? sram_bus.rvalid : periph_bus.rvalid);
  assign up.rdata = rd_to_sram ? sram_bus.rdata : periph_bus.rdata;
  assign up.rresp = rd_to_sram ? sram_bus.rresp : periph_bus.rresp;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state <= subsystem_pkg::wr_idle;
      wr_target <= subsystem_pkg::sram;
    end else begin
      case (wr_state)
        subsystem_pkg::wr_idle: begin
          if (up.awvalid && up.awready) begin
            wr_target <= aw_pick;
            wr_state <= subsystem_pkg::wr_data;
          end
        end
        subsystem_pkg::wr_data: begin
          if (up.wvalid && up.wready) begin
            wr_state <= subsystem_pkg::wr_resp;
          end
        end
        subsystem_pkg::wr_resp: begin
          if (up.bvalid && up.bready) begin
            wr_state <= subsystem_pkg::wr_idle;
          end
        end
        default: wr_state <= subsystem_pkg::wr_idle;
      endcase
    end
  end

  // reads run independently of writes.
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= subsystem_pkg::rd_idle;
      rd_target <= subsystem_pkg::sram;
    end else begin
      case (rd_state)
        subsystem_pkg::rd_idle: begin
          if (up.arvalid && up.arready) begin
            rd_target <= ar_pick;
            rd_state <= subsystem_pkg::rd_busy;
          end
        end
        subsystem_pkg::rd_busy: begin
          if (up.rvalid && up.rready) begin
            rd_state <= subsystem_pkg::rd_idle;
          end
        end
        default: rd_state <= subsystem_pkg::rd_idle;
      endcase
    end
  end

endmodule

/* sram_axi_controller.sv */
/*
  AXI4-Lite code SRAM controller.
  Turns single writes and reads into SRAM cycles, one of each in flight.
*/
`timescale 1ns/1ps
`include "subsystem_cfg.svh"

module sram_axi_controller (
  input logic clock,
  input logic reset,
  axi_lite_if.subordinate bus,
  sram_if.controller mem
);

  subsystem_pkg::wr_state_e wr_state;
  subsystem_pkg::rd_state_e rd_state;
  subsystem_pkg::sram_index_t wr_index;
  subsystem_pkg::sram_index_t rd_index;
  subsystem_pkg::data_t rd_word;
  logic rd_issued;

  assign bus.awready = wr_state == subsystem_pkg::wr_idle;
  assign bus.wready = wr_state == subsystem_pkg::wr_data;
  assign bus.bvalid = wr_state == subsystem_pkg::wr_resp;
  assign bus.bresp = `SUB_RESP_OKAY;

  // memory written on the w transfer edge.
  assign mem.write_enable = bus.wvalid && bus.wready;
  assign mem.write_index = wr_index;
  assign mem.write_data = bus.wdata;
  assign mem.write_strb = bus.wstrb;

  assign bus.arready = rd_state == subsystem_pkg::rd_idle;
  assign bus.rvalid = rd_state == subsystem_pkg::rd_resp;
  assign bus.rdata = rd_word;
  assign bus.rresp = `SUB_RESP_OKAY;

  assign mem.read_enable = (rd_state == subsystem_pkg::rd_busy) && !rd_issued;
  assign mem.read_index = rd_index;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state <= subsystem_pkg::wr_idle;
    end else begin
      case (wr_state)
        subsystem_pkg::wr_idle: begin
          if (bus.awvalid && bus.awready) begin
            wr_state <= subsystem_pkg::wr_data;
          end
        end
        subsystem_pkg::wr_data: begin
          if (bus.wvalid && bus.wready) begin
            wr_state <= subsystem_pkg::wr_resp;
          end
        end
        subsystem_pkg::wr_resp: begin
          if (bus.bready) begin
            wr_state <= subsystem_pkg::wr_idle;
          end
        end
        default: wr_state <= subsystem_pkg::wr_idle;
      endcase
    end
  end

  // issue cycle, then capture cycle, then hold until rready.
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= subsystem_pkg::rd_idle;
      rd_issued <= 1'b0;
    end else begin
      case (rd_state)
        subsystem_pkg::rd_idle: begin
          if (bus.arvalid && bus.arready) begin
            rd_state <= subsystem_pkg::rd_busy;
          end
        end
        subsystem_pkg::rd_busy: begin
          if (!rd_issued) begin
            rd_issued <= 1'b1;
          end else begin
            rd_issued <= 1'b0;
            rd_state <= subsystem_pkg::rd_resp;
          end
        end
        subsystem_pkg::rd_resp: begin
          if (bus.rready) begin
            rd_state <= subsystem_pkg::rd_idle;
          end
        end
        default: rd_state <= subsystem_pkg::rd_idle;
      endcase
    end
  end

  // word index is address bits 10 to 3.
  always_ff @(posedge clock) begin
    if (bus.awvalid && bus.awready) begin
      wr_index <= bus.awaddr[`SUB_SRAM_INDEX_BITS+2:3];
    end
    if (bus.arvalid && bus.arready) begin
      rd_index <= bus.araddr[`SUB_SRAM_INDEX_BITS+2:3];
    end
    if ((rd_state == subsystem_pkg::rd_busy) && rd_issued) begin
      rd_word <= mem.read_data;
    end
  end

endmodule

/* code_sram.sv */
/*
  Code SRAM.
  Word array with per-byte write enables and a registered read.
*/
`timescale 1ns/1ps
`include "subsystem_cfg.svh"

module code_sram (
  input logic clock,
  sram_if.memory mem
);

  subsystem_pkg::data_t mem_array [0:(1 << `SUB_SRAM_INDEX_BITS)-1];

  always_ff @(posedge clock) begin
    if (mem.write_enable) begin
      for (int i = 0; i < `SUB_DATA_BITS/8; i++) begin
        if (mem.write_strb[i]) begin
          mem_array[mem.write_index][8*i +: 8] <= mem.write_data[8*i +: 8];
        end
      end
    end
  end

  // read register only moves when enabled.
  always_ff @(posedge clock) begin
    if (mem.read_enable) begin
      mem.read_data <= mem_array[mem.read_index];
    end
  end

endmodule

/* periph_lane_bridge.sv */
/*
  Peripheral lane bridge.
  Narrows the 64-bit AXI4-Lite bus to the 32-bit peripheral message
  port, choosing the upper or lower half by address bit 2.
*/
`timescale 1ns/1ps
`include "subsystem_cfg.svh"

module periph_lane_bridge (
  input logic clock,
  input logic reset,
  axi_lite_if.subordinate bus,
  output subsystem_pkg::addr_t periph_aw_msg,
  output logic periph_aw_valid,
  input logic periph_aw_ready,
  output logic [$bits(subsystem_pkg::periph_strb_t)+$bits(subsystem_pkg::periph_data_t)-1:0]
    periph_w_msg,
  output logic periph_w_valid,
  input logic periph_w_ready,
  input subsystem_pkg::resp_t periph_b_msg,
  input logic periph_b_valid,
  output logic periph_b_ready,
  output subsystem_pkg::addr_t periph_ar_msg,
  output logic periph_ar_valid,
  input logic periph_ar_ready,
  input logic [$bits(subsystem_pkg::resp_t)+$bits(subsystem_pkg::periph_data_t)-1:0]
    periph_r_msg,
  input logic periph_r_valid,
  output logic periph_r_ready
);

  logic w_lane;
  logic r_lane;
  subsystem_pkg::periph_data_t w_data;
  subsystem_pkg::periph_strb_t w_strb;
  subsystem_pkg::periph_data_t r_data;
  subsystem_pkg::resp_t r_resp;

  // lane of the write and read in flight.
  always_ff @(posedge clock) begin
    if (reset) begin
      w_lane <= 1'b0;
      r_lane <= 1'b0;
    end else begin
      if (bus.awvalid && bus.awready) begin
        w_lane <= bus.awaddr[`SUB_LANE_BIT];
      end
      if (bus.arvalid && bus.arready) begin
        r_lane <= bus.araddr[`SUB_LANE_BIT];
      end
    end
  end

  assign w_data = w_lane ? bus.wdata[`SUB_PERIPH_DATA_BITS +: `SUB_PERIPH_DATA_BITS]
                         : bus.wdata[0 +: `SUB_PERIPH_DATA_BITS];
  assign w_strb = w_lane ? bus.wstrb[`SUB_PERIPH_DATA_BITS/8 +: `SUB_PERIPH_DATA_BITS/8]
                         : bus.wstrb[0 +: `SUB_PERIPH_DATA_BITS/8];

  assign periph_aw_msg = bus.awaddr;
  assign periph_aw_valid = bus.awvalid;
  assign bus.awready = periph_aw_ready;

  assign periph_w_msg = {w_strb, w_data};
  assign periph_w_valid = bus.wvalid;
  assign bus.wready = periph_w_ready;

  assign bus.bresp = periph_b_msg;
  assign bus.bvalid = periph_b_valid;
  assign periph_b_ready = bus.bready;

  assign periph_ar_msg = bus.araddr;
  assign periph_ar_valid = bus.arvalid;
  assign bus.arready = periph_ar_ready;

  // other half of rdata reads as zero.
  assign {r_resp, r_data} = periph_r_msg;
  assign bus.rdata = r_lane ? {r_data, {`SUB_PERIPH_DATA_BITS{1'b0}}}
                            : {{`SUB_PERIPH_DATA_BITS{1'b0}}, r_data};
  assign bus.rresp = r_resp;
  assign bus.rvalid = periph_r_valid;
  assign periph_r_ready = bus.rready;

endmodule

/* subsystem_top.sv */
/*
  Memory and peripheral fabric top level.
  AXI4-Lite target port decoded to the code SRAM and the peripheral port.
*/
`timescale 1ns/1ps

module subsystem_top (
  input logic clock,
  input logic reset,
  input subsystem_pkg::addr_t awaddr,
  input logic awvalid,
  output logic awready,
  input subsystem_pkg::data_t wdata,
  input subsystem_pkg::strb_t wstrb,
  input logic wvalid,
  output logic wready,
  output subsystem_pkg::resp_t bresp,
  output logic bvalid,
  input logic bready,
  input subsystem_pkg::addr_t araddr,
  input logic arvalid,
  output logic arready,
  output subsystem_pkg::data_t rdata,
  output subsystem_pkg::resp_t rresp,
  output logic rvalid,
  input logic rready,
  output subsystem_pkg::addr_t periph_aw_msg,
  output logic periph_aw_valid,
  input logic periph_aw_ready,
  output logic [$bits(subsystem_pkg::periph_strb_t)+$bits(subsystem_pkg::periph_data_t)-1:0]
    periph_w_msg,
  output logic periph_w_valid,
  input logic periph_w_ready,
  input subsystem_pkg::resp_t periph_b_msg,
  input logic periph_b_valid,
  output logic periph_b_ready,
  output subsystem_pkg::addr_t periph_ar_msg,
  output logic periph_ar_valid,
  input logic periph_ar_ready,
  input logic [$bits(subsystem_pkg::resp_t)+$bits(subsystem_pkg::periph_data_t)-1:0]
    periph_r_msg,
  input logic periph_r_valid,
  output logic periph_r_ready
);

  axi_lite_if up_bus ();
  axi_lite_if sram_bus ();
  axi_lite_if periph_bus ();
  sram_if sram_port ();

  // top ports onto the upstream bus.
  assign up_bus.awaddr = awaddr;
  assign up_bus.awvalid = awvalid;
  assign awready = up_bus.awready;
  assign up_bus.wdata = wdata;
  assign up_bus.wstrb = wstrb;
  assign up_bus.wvalid = wvalid;
  assign wready = up_bus.wready;
  assign bresp = up_bus.bresp;
  assign bvalid = up_bus.bvalid;
  assign up_bus.bready = bready;
  assign up_bus.araddr = araddr;
  assign up_bus.arvalid = arvalid;
  assign arready = up_bus.arready;
  assign rdata = up_bus.rdata;
  assign rresp = up_bus.rresp;
  assign rvalid = up_bus.rvalid;
  assign up_bus.rready = rready;

  axi_addr_decoder decoder0 (
    .clock(clock),
    .reset(reset),
    .up(up_bus),
    .sram_bus(sram_bus),
    .periph_bus(periph_bus)
  );

  sram_axi_controller sram_ctrl0 (
    .clock(clock),
    .reset(reset),
    .bus(sram_bus),
    .mem(sram_port)
  );

  code_sram code_mem0 (
    .clock(clock),
    .mem(sram_port)
  );

  periph_lane_bridge bridge0 (
    .clock(clock),
    .reset(reset),
    .bus(periph_bus),
    .periph_aw_msg(periph_aw_msg),
    .periph_aw_valid(periph_aw_valid),
    .periph_aw_ready(periph_aw_ready),
    .periph_w_msg(periph_w_msg),
    .periph_w_valid(periph_w_valid),
    .periph_w_ready(periph_w_ready),
    .periph_b_msg(periph_b_msg),
    .periph_b_valid(periph_b_valid),
    .periph_b_ready(periph_b_ready),
    .periph_ar_msg(periph_ar_msg),
    .periph_ar_valid(periph_ar_valid),
    .periph_ar_ready(periph_ar_ready),
    .periph_r_msg(periph_r_msg),
    .periph_r_valid(periph_r_valid),
    .periph_r_ready(periph_r_ready)
  );

endmodule

/* tb_subsystem.sv */
/*
  Testbench for the memory and peripheral fabric.
  Drives the AXI4-Lite port, answers the peripheral message port,
  predicts SRAM contents with a shadow array and checks responses.
*/
`timescale 1ns/1ps
`include "subsystem_cfg.svh"

module tb_subsystem;

  localparam int wait_limit = 200;
  localparam int sig_awready = 0;
  localparam int sig_wready = 1;
  localparam int sig_bvalid = 2;
  localparam int sig_arready = 3;
  localparam int sig_rvalid = 4;

  logic clock;
  logic reset;
  subsystem_pkg::addr_t awaddr;
  logic awvalid;
  logic awready;
  subsystem_pkg::data_t wdata;
  subsystem_pkg::strb_t wstrb;
  logic wvalid;
  logic wready;
  subsystem_pkg::resp_t bresp;
  logic bvalid;
  logic bready;
  subsystem_pkg::addr_t araddr;
  logic arvalid;
  logic arready;
  subsystem_pkg::data_t rdata;
  subsystem_pkg::resp_t rresp;
  logic rvalid;
  logic rready;

  subsystem_pkg::addr_t periph_aw_msg;
  logic periph_aw_valid;
  logic periph_aw_ready = 1'b0;
  logic [35:0] periph_w_msg;
  logic periph_w_valid;
  logic periph_w_ready = 1'b0;
  subsystem_pkg::resp_t periph_b_msg = 2'b00;
  logic periph_b_valid = 1'b0;
  logic periph_b_ready;
  subsystem_pkg::addr_t periph_ar_msg;
  logic periph_ar_valid;
  logic periph_ar_ready = 1'b0;
  logic [33:0] periph_r_msg = 34'd0;
  logic periph_r_valid = 1'b0;
  logic periph_r_ready;

  // responder outputs, decided at the falling edge.
  logic nxt_aw_ready = 1'b0;
  logic nxt_w_ready = 1'b0;
  logic nxt_ar_ready = 1'b0;
  logic nxt_b_valid = 1'b0;
  logic nxt_r_valid = 1'b0;
  subsystem_pkg::resp_t nxt_b_msg = 2'b00;
  logic [33:0] nxt_r_msg = 34'd0;
  logic b_armed = 1'b0;
  logic r_armed = 1'b0;
  logic [1:0] b_delay = 2'd0;
  logic [1:0] r_delay = 2'd0;
  logic wr_pending = 1'b0;
  logic rd_pending = 1'b0;

  logic [15:0] lfsr_state = 16'd89;
  subsystem_pkg::addr_t exp_aw_addr;
  subsystem_pkg::addr_t exp_ar_addr;
  logic [35:0] exp_w_msg;
  subsystem_pkg::data_t shadow [0:255];
  int check_errors = 0;
  int assert_errors = 0;

  subsystem_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit.
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic feedback;
    value = 32'd0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], feedback};
      value = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic probe(input int which);
    case (which)
      sig_awready: return awready;
      sig_wready: return wready;
      sig_bvalid: return bvalid;
      sig_arready: return arready;
      sig_rvalid: return rvalid;
      default: return 1'b0;
    endcase
  endfunction

  // returns at the falling edge where the signal is high.
  task automatic wait_for(input int which, input string what);
    int t;
    t = 0;
    do begin
      @(negedge clock);
      t++;
    end while (!probe(which) && t < wait_limit);
    if (!probe(which)) begin
      $display("timeout waiting for %s at %0t", what, $time);
      $display("Verification failed");
      $finish;
    end
  endtask

  task automatic axi_write(input subsystem_pkg::addr_t a, input subsystem_pkg::data_t d,
                           input subsystem_pkg::strb_t s, input int bp);
    subsystem_pkg::resp_t expected;
    logic again;
    exp_aw_addr = a;
    exp_w_msg = a[`SUB_LANE_BIT] ? {s[7:4], d[63:32]} : {s[3:0], d[31:0]};
    again = 1'b0;
    @(posedge clock);
    #1;
    awaddr = a;
    awvalid = 1'b1;
    bready = (bp == 0);
    do begin
      wait_for(sig_awready, "awready");
      @(posedge clock);
      #1;
      awvalid = 1'b0;
      wdata = d;
      wstrb = s;
      wvalid = 1'b1;
      wait_for(sig_wready, "wready");
      @(posedge clock);
      #1;
      wvalid = 1'b0;
      wait_for(sig_bvalid, "bvalid");
      // a held peripheral write offers the same address again.
      again = !again && (bp > 0) && !a[`SUB_SRAM_SELECT_BIT];
      if (bp > 0) begin
        if (again) begin
          @(posedge clock);
          #1;
          awvalid = 1'b1;
        end
        repeat (bp) @(negedge clock);
        @(posedge clock);
        #1;
        bready = 1'b1;
        @(negedge clock);
      end
      expected = a[`SUB_SRAM_SELECT_BIT] ? `SUB_RESP_OKAY : nxt_b_msg;
      assert (bvalid && bresp === expected) else begin
        check_errors++;
        $display("mismatch at %0t: bresp %0h expected %0h", $time, bresp, expected);
      end
      if (a[`SUB_SRAM_SELECT_BIT]) begin
        for (int i = 0; i < 8; i++) begin
          if (s[i]) shadow[a[10:3]][8*i +: 8] = d[8*i +: 8];
        end
      end
      @(posedge clock);
      #1;
      bready = 1'b0;
    end while (again);
  endtask

  task automatic axi_read(input subsystem_pkg::addr_t a, input int bp);
    subsystem_pkg::data_t expected;
    subsystem_pkg::resp_t exp_resp;
    int cycles;
    logic again;
    exp_ar_addr = a;
    again = 1'b0;
    @(posedge clock);
    #1;
    araddr = a;
    arvalid = 1'b1;
    rready = (bp == 0);
    do begin
      wait_for(sig_arready, "arready");
      @(posedge clock);
      #1;
      arvalid = 1'b0;
      cycles = 0;
      do begin
        @(negedge clock);
        cycles++;
      end while (!rvalid && cycles < wait_limit);
      if (!rvalid) begin
        $display("timeout waiting for rvalid at %0t", $time);
        $display("Verification failed");
        $finish;
      end
      // the first falling edge counted follows the transfer edge.
      if (a[`SUB_SRAM_SELECT_BIT] && bp == 0) begin
        assert (cycles - 1 == 2) else begin
          check_errors++;
          $display("mismatch at %0t: read latency %0d expected 2", $time, cycles - 1);
        end
      end
      // a held peripheral read offers the same address again.
      again = !again && (bp > 0) && !a[`SUB_SRAM_SELECT_BIT];
      if (bp > 0) begin
        if (again) begin
          @(posedge clock);
          #1;
          arvalid = 1'b1;
        end
        repeat (bp) @(negedge clock);
        @(posedge clock);
        #1;
        rready = 1'b1;
        @(negedge clock);
      end
      if (a[`SUB_SRAM_SELECT_BIT]) begin
        expected = shadow[a[10:3]];
        exp_resp = `SUB_RESP_OKAY;
      end else begin
        expected = a[`SUB_LANE_BIT] ? {nxt_r_msg[31:0], 32'd0} : {32'd0, nxt_r_msg[31:0]};
        exp_resp = nxt_r_msg[33:32];
      end
      assert (rvalid && rdata === expected && rresp === exp_resp) else begin
        check_errors++;
        $display("mismatch at %0t: rdata %0h/%0h expected %0h/%0h",
                 $time, rdata, rresp, expected, exp_resp);
      end
      @(posedge clock);
      #1;
      rready = 1'b0;
    end while (again);
  endtask

  // peripheral responder, decisions on the falling edge.
  always @(negedge clock) begin
    if (reset) begin
      nxt_aw_ready = 1'b0;
      nxt_w_ready = 1'b0;
      nxt_ar_ready = 1'b0;
      nxt_b_valid = 1'b0;
      nxt_r_valid = 1'b0;
      b_armed = 1'b0;
      r_armed = 1'b0;
    end else begin
      if (periph_aw_valid && periph_aw_ready) begin
        assert (periph_aw_msg === exp_aw_addr) else begin
          check_errors++;
          $display("mismatch at %0t: periph_aw_msg %0h", $time, periph_aw_msg);
        end
      end
      if (periph_ar_valid && periph_ar_ready) begin
        assert (periph_ar_msg === exp_ar_addr) else begin
          check_errors++;
          $display("mismatch at %0t: periph_ar_msg %0h", $time, periph_ar_msg);
        end
        r_delay = 2'(random_bits(2));
        r_armed = 1'b1;
      end
      if (periph_w_valid && periph_w_ready) begin
        assert (periph_w_msg === exp_w_msg) else begin
          check_errors++;
          $display("mismatch at %0t: periph_w_msg %0h expected %0h",
                   $time, periph_w_msg, exp_w_msg);
        end
        b_delay = 2'(random_bits(2));
        b_armed = 1'b1;
      end
      if (periph_b_valid && periph_b_ready) begin
        nxt_b_valid = 1'b0;
      end else if (b_armed) begin
        if (b_delay == 2'd0) begin
          nxt_b_valid = 1'b1;
          nxt_b_msg = subsystem_pkg::resp_t'(random_bits(2));
          b_armed = 1'b0;
        end else begin
          b_delay = b_delay - 2'd1;
        end
      end
      if (periph_r_valid && periph_r_ready) begin
        nxt_r_valid = 1'b0;
      end else if (r_armed) begin
        if (r_delay == 2'd0) begin
          nxt_r_valid = 1'b1;
          nxt_r_msg = {2'(random_bits(2)), random_bits(32)};
          r_armed = 1'b0;
        end else begin
          r_delay = r_delay - 2'd1;
        end
      end
      nxt_aw_ready = 1'(random_bits(1));
      nxt_w_ready = 1'(random_bits(1));
      nxt_ar_ready = 1'(random_bits(1));
    end
  end

  always @(posedge clock) begin
    if (periph_aw_valid && periph_aw_ready) wr_pending <= 1'b1;
    else if (periph_b_valid && periph_b_ready) wr_pending <= 1'b0;
    if (periph_ar_valid && periph_ar_ready) rd_pending <= 1'b1;
    else if (periph_r_valid && periph_r_ready) rd_pending <= 1'b0;
    #1;
    periph_aw_ready = nxt_aw_ready;
    periph_w_ready = nxt_w_ready;
    periph_ar_ready = nxt_ar_ready;
    periph_b_valid = nxt_b_valid;
    periph_b_msg = nxt_b_msg;
    periph_r_valid = nxt_r_valid;
    periph_r_msg = nxt_r_msg;
  end

  assert property (@(posedge clock) disable iff (reset)
                   (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else begin
      assert_errors++;
      $display("bvalid dropped or bresp changed before bready at %0t", $time);
    end

  assert property (@(posedge clock) disable iff (reset)
                   (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
      assert_errors++;
      $display("rvalid dropped or read payload changed before rready at %0t", $time);
    end

  assert property (@(posedge clock) disable iff (reset) !(wr_pending && periph_aw_valid))
    else begin
      assert_errors++;
      $display("second peripheral write address while a response is pending at %0t", $time);
    end

  assert property (@(posedge clock) disable iff (reset) !(rd_pending && periph_ar_valid))
    else begin
      assert_errors++;
      $display("second peripheral read address while a response is pending at %0t", $time);
    end

  initial begin
    subsystem_pkg::addr_t a;
    subsystem_pkg::data_t d;
    subsystem_pkg::strb_t s;
    int bp;
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    assert ({awready, wready, bvalid, arready, rvalid, periph_aw_valid, periph_w_valid,
             periph_ar_valid, periph_b_ready, periph_r_ready} == 10'd0)
      else begin
        check_errors++;
        $display("mismatch at %0t: outputs active after reset", $time);
      end

    // preload the first 16 SRAM words.
    for (int i = 0; i < 16; i++) begin
      a = 32'h8000_0000;
      a[6:3] = i[3:0];
      axi_write(a, {random_bits(32), random_bits(32)}, 8'hff, 0);
    end
    for (int i = 0; i < 24; i++) begin
      a = 32'h8000_0000;
      a[6:3] = 4'(random_bits(4));
      d = {random_bits(32), random_bits(32)};
      s = subsystem_pkg::strb_t'(random_bits(8));
      bp = int'(random_bits(2));
      axi_write(a, d, s, bp);
      axi_read(a, 0);
      a[6:3] = 4'(random_bits(4));
      axi_read(a, int'(random_bits(2)));
    end

    // peripheral lanes, with back-pressure.
    for (int i = 0; i < 16; i++) begin
      a = random_bits(32);
      a[31] = 1'b0;
      axi_write(a, {random_bits(32), random_bits(32)},
                subsystem_pkg::strb_t'(random_bits(8)), int'(random_bits(2)));
      a = random_bits(32);
      a[31] = 1'b0;
      axi_read(a, int'(random_bits(2)));
    end

    $display("errors: %0d checks, %0d assertions", check_errors, assert_errors);
    if (check_errors + assert_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
subsystem_pkg.sv
axi_lite_if.sv
sram_if.sv
axi_addr_decoder.sv
sram_axi_controller.sv
code_sram.sv
periph_lane_bridge.sv
subsystem_top.sv
tb_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_subsystem -f compile.f
./obj_dir/Vtb_subsystem > sim.log 2>&1 || true
cat sim.log
if grep -q "^Verification passed$" sim.log; then
  exit 0
else
  exit 1
fi
